// File: Bender.yml
package:
  name: agc_dsa

sources:
  - include_dirs:
      - .
    files:
      - agc_pkg.sv
      - agc_channel.sv
      - dsa_write_arbiter.sv
      - agc_dsa_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_agc_dsa.sv

// File: agc_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module agc_channel (
    input  wire                     axi_clk,
    input  wire                     axi_resetn,
    input  wire                     tick,               // clock enable, 1 in 4
    input  wire                     adc_over_range,
    input  wire                     adc_over_voltage,
    input  wire                     adcp_disable,       // software takes over
    input  wire agc_pkg::agc_code_t ps_rxdsa,           // commanded code / floor
    input  wire                     ps_bypass_lna,
    input  wire                     done,               // write finished, one tick
    output agc_pkg::agc_code_t      pl_rxdsa,
    output logic                    rx_lna_bypass,
    output agc_pkg::dsa_req_t       req
);

    import agc_pkg::*;

    localparam int HOLD_W = $clog2(`AGC_HOLD_TICKS + 1);

    agc_code_t              code_q;                     // current attenuation
    agc_code_t              code_d;
    logic [HOLD_W-1:0]      hold_q;                     // quiet tick count
    logic [HOLD_W-1:0]      hold_d;
    agc_code_t              written_q;                  // last code on the bus
    agc_code_t              written_d;
    logic                   pending_q;
    agc_code_t              hist1_q;                    // code one tick back
    agc_code_t              hist2_q;                    // code two ticks back
    logic [7:0]             step;                       // attack step this tick
    logic [7:0]             sum_up;                     // one extra bit for carry
    logic                   attack;

    // over-voltage step wins over over-range
    always_comb begin
        step = 8'd0;
        if (adc_over_voltage) begin
            step = 8'(`AGC_OV_STEP);
        end else if (adc_over_range) begin
            step = 8'(`AGC_OR_STEP);
        end
    end

    assign attack = adc_over_voltage | adc_over_range;
    assign sum_up = {1'b0, code_q} + step;

    // next code and hold count, applied on tick only
    always_comb begin
        code_d = code_q;
        hold_d = hold_q;
        if (adcp_disable) begin
            code_d = ps_rxdsa;                          // follow software
            hold_d = '0;
        end else if (attack) begin
            if (sum_up > 8'(`AGC_CODE_MAX)) begin
                code_d = agc_code_t'(`AGC_CODE_MAX);    // saturate
            end else begin
                code_d = sum_up[6:0];
            end
            hold_d = '0;                                // restart hold
        end else if (code_q < ps_rxdsa) begin
            code_d = ps_rxdsa;                          // floor raised, jump up
        end else if (hold_q != HOLD_W'(`AGC_HOLD_TICKS)) begin
            hold_d = hold_q + 1'b1;                     // still holding
        end else if (code_q > ps_rxdsa) begin
            code_d = code_q - 1'b1;                     // decay one step
        end
    end

    // bus data was sampled by the arbiter two ticks before done reaches us
    assign written_d = done ? hist2_q : written_q;

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            code_q    <= '0;
            hold_q    <= '0;
            written_q <= '0;
            pending_q <= 1'b0;
        end else if (tick) begin
            code_q    <= code_d;
            hold_q    <= hold_d;
            written_q <= written_d;
            pending_q <= (code_d != written_d);         // latest value wins
        end
    end

    // code history, lines up with the bus data when done arrives
    always_ff @(posedge axi_clk) begin
        if (tick) begin
            hist1_q <= code_q;
            hist2_q <= hist1_q;
        end
    end

    assign pl_rxdsa    = code_q;
    assign req.pending = pending_q;
    assign req.code    = code_q;

    // auto bypass only while the loop is running
    assign rx_lna_bypass = ps_bypass_lna |
                           (~adcp_disable & (code_q >= agc_code_t'(`AGC_LNA_THRESH)));

endmodule

`default_nettype wire

// File: agc_consts.svh
`ifndef AGC_CONSTS_SVH
`define AGC_CONSTS_SVH

// channel count, fixed by the board
`define AGC_NUM_CH      4

// clocks per clock-enable tick
`define AGC_TICK_DIV    4

// attenuation added per tick on over-range
`define AGC_OR_STEP     1

// attenuation added per tick on over-voltage, wins over over-range
`define AGC_OV_STEP     4

// quiet ticks before the code starts to relax
`define AGC_HOLD_TICKS  8

// code at or above this bypasses the lna
`define AGC_LNA_THRESH  96

// top of the 7-bit dsa range
`define AGC_CODE_MAX    127

`endif

// File: agc_dsa_cases.txt
// over_range over_voltage disable bypass ps0 ps1 ps2 ps3 hold_ticks
// exp0 exp1 exp2 exp3 exp_bypass bus_check (1 settle, 2 settle and round-robin)
// all disabled, distinct commanded codes
0 0 f 0 0a 14 1e 28 3 0a 14 1e 28 0 1
// over-voltage on ch0, 5 then 30 ticks
0 1 e 0 0a 14 1e 28 5 1e 14 1e 28 0 0
0 1 e 0 0a 14 1e 28 1e 7f 14 1e 28 1 0
// flags drop, hold 8 then decay
0 0 e 0 0a 14 1e 28 8 7f 14 1e 28 1 0
0 0 e 0 0a 14 1e 28 a 75 14 1e 28 1 0
0 0 e 0 0a 14 1e 28 19 5c 14 1e 28 0 0
// over-range on ch1, then both flags
2 0 c 0 0a 14 1e 28 6 56 1a 1e 28 0 0
2 2 c 0 0a 14 1e 28 3 53 26 1e 28 0 0
// commanded bypass on ch2
0 0 c 4 0a 14 1e 28 2 51 26 1e 28 4 0
// floor raised on ch0 to the threshold
0 0 c 0 60 14 1e 28 2 60 26 1e 28 1 0
// all four change together
0 0 f 0 05 15 25 35 3 05 15 25 35 0 2
// ch3 loop, attack then relax to its floor
0 8 7 0 05 15 25 35 4 05 15 25 45 0 0
0 0 7 0 05 15 25 35 9 05 15 25 44 0 0
0 0 7 0 05 15 25 35 14 05 15 25 35 0 1

// File: agc_dsa_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module agc_dsa_top (
    input  wire                                         axi_clk,
    input  wire                                         axi_resetn,
    input  wire [`AGC_NUM_CH-1:0]                       adc_over_range,
    input  wire [`AGC_NUM_CH-1:0]                       adc_over_voltage,
    input  wire [`AGC_NUM_CH-1:0]                       adcp_disable,
    input  wire agc_pkg::agc_code_t [`AGC_NUM_CH-1:0]   ps_rxdsa,
    input  wire [`AGC_NUM_CH-1:0]                       ps_bypass_lna,
    output wire agc_pkg::agc_code_t [`AGC_NUM_CH-1:0]   pl_rxdsa,
    output wire [`AGC_NUM_CH-1:0]                       rx_lna_bypass,
    output wire agc_pkg::dsa_bus_t                      dsa_bus
);

    import agc_pkg::*;

    wire dsa_req_t [`AGC_NUM_CH-1:0]    req;            // channel to arbiter
    wire                                tick;
    wire [`AGC_NUM_CH-1:0]              done;

    // index 0 drives latch enable 1 on the board
    for (genvar i = 0; i < `AGC_NUM_CH; i++) begin : gen_ch
        agc_channel i_channel (
            .axi_clk          (axi_clk),
            .axi_resetn       (axi_resetn),
            .tick             (tick),
            .adc_over_range   (adc_over_range[i]),
            .adc_over_voltage (adc_over_voltage[i]),
            .adcp_disable     (adcp_disable[i]),
            .ps_rxdsa         (ps_rxdsa[i]),
            .ps_bypass_lna    (ps_bypass_lna[i]),
            .done             (done[i]),
            .pl_rxdsa         (pl_rxdsa[i]),
            .rx_lna_bypass    (rx_lna_bypass[i]),
            .req              (req[i])
        );
    end

    dsa_write_arbiter i_arbiter (
        .axi_clk    (axi_clk),
        .axi_resetn (axi_resetn),
        .req        (req),
        .tick       (tick),                             // shared clock enable
        .done       (done),
        .dsa_bus    (dsa_bus)
    );

endmodule

`default_nettype wire

// File: agc_pkg.sv
`default_nettype none

`include "agc_consts.svh"

package agc_pkg;

    // dsa attenuation, one step per lsb
    typedef logic [6:0] agc_code_t;

    // per-channel write request to the shared dsa bus
    typedef struct packed {
        logic       pending;            // code differs from last written
        agc_code_t  code;               // latest code, written when served
    } dsa_req_t;

    // shared parallel bus to the attenuators
    typedef struct packed {
        agc_code_t                  data;   // common data lines
        logic [`AGC_NUM_CH-1:0]     le;     // one latch enable per part
    } dsa_bus_t;

endpackage

`default_nettype wire

// File: dsa_write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module dsa_write_arbiter (
    input  wire                                         axi_clk,
    input  wire                                         axi_resetn,
    input  wire agc_pkg::dsa_req_t [`AGC_NUM_CH-1:0]    req,
    output logic                                        tick,       // 1 cycle in 4
    output logic [`AGC_NUM_CH-1:0]                      done,       // one tick per write
    output agc_pkg::dsa_bus_t                           dsa_bus
);

    import agc_pkg::*;

    localparam int CNT_W = $clog2(`AGC_TICK_DIV);
    localparam int PTR_W = $clog2(`AGC_NUM_CH);

    // write sequence, one state per tick
    typedef enum logic [1:0] {
        SET_DATA  = 2'd0,                               // wait for a request, drive data
        SET_LE    = 2'd1,                               // pulse the latch enable
        REMOVE_LE = 2'd2                                // hold data one more tick
    } seq_t;

    logic [CNT_W-1:0]       div_q;                      // tick divider
    logic [PTR_W-1:0]       ptr_q;                      // round-robin pointer
    logic [PTR_W-1:0]       ptr_d;
    logic [PTR_W-1:0]       sel_q;                      // channel being written
    logic [`AGC_NUM_CH-1:0] sel_oh;
    logic                   stay;
    seq_t                   seq_q;
    dsa_bus_t               bus_q;
    logic [`AGC_NUM_CH-1:0] done_q;

    // clock enable for the slow dsa bus
    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            div_q <= '0;
        end else if (div_q == CNT_W'(`AGC_TICK_DIV - 1)) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign tick = (div_q == CNT_W'(`AGC_TICK_DIV - 1));

    // park on a pending channel until its done is seen
    assign stay = req[ptr_q].pending & ~done[ptr_q];

    always_comb begin
        if (stay) begin
            ptr_d = ptr_q;
        end else if (ptr_q == PTR_W'(`AGC_NUM_CH - 1)) begin
            ptr_d = '0;                                 // wrap to channel 1
        end else begin
            ptr_d = ptr_q + 1'b1;
        end
    end

    // pending may drop mid-write, so the served channel is latched
    assign sel_oh = `AGC_NUM_CH'(1) << sel_q;

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            ptr_q  <= '0;
            sel_q  <= '0;
            seq_q  <= SET_DATA;
            bus_q  <= '0;                               // data and enables low
            done_q <= '0;
        end else if (tick) begin
            ptr_q <= ptr_d;
            case (seq_q)
                SET_DATA: begin
                    if (stay) begin
                        bus_q.data <= req[ptr_q].code;  // setup tick
                        sel_q      <= ptr_q;
                        seq_q      <= SET_LE;
                    end
                end
                SET_LE: begin
                    bus_q.le <= sel_oh;                 // latch strobe
                    done_q   <= sel_oh;
                    seq_q    <= REMOVE_LE;
                end
                REMOVE_LE: begin
                    bus_q.le <= '0;                     // data still held
                    done_q   <= '0;
                    seq_q    <= SET_DATA;
                end
                default: begin
                    bus_q.le <= '0;
                    done_q   <= '0;
                    seq_q    <= SET_DATA;
                end
            endcase
        end
    end

    assign done    = done_q;
    assign dsa_bus = bus_q;

endmodule

`default_nettype wire

// File: project.f
+incdir+.
agc_pkg.sv
agc_channel.sv
dsa_write_arbiter.sv
agc_dsa_top.sv
tb_clock_gen.sv
tb_agc_dsa.sv

// File: tb_agc_dsa.sv
`timescale 1ns/1ps
`default_nettype none

`include "agc_consts.svh"

module tb_agc_dsa;

    import agc_pkg::*;

    localparam int NUM_FIELDS = 15;                 // values per case line
    localparam int MAX_CASES  = 32;

    logic                           axi_clk;
    logic                           axi_resetn;
    logic [`AGC_NUM_CH-1:0]         adc_or;
    logic [`AGC_NUM_CH-1:0]         adc_ov;
    logic [`AGC_NUM_CH-1:0]         dis;
    logic [`AGC_NUM_CH-1:0]         byp;
    agc_code_t [`AGC_NUM_CH-1:0]    ps;
    agc_code_t [`AGC_NUM_CH-1:0]    pl_rxdsa;
    logic [`AGC_NUM_CH-1:0]         rx_lna_bypass;
    dsa_bus_t                       dsa_bus;

    logic [31:0]    case_mem [0:NUM_FIELDS*MAX_CASES-1];
    int             errors;
    agc_code_t      m_code  [`AGC_NUM_CH];          // reference gain loop
    agc_code_t      m_prev1 [`AGC_NUM_CH];
    agc_code_t      m_prev2 [`AGC_NUM_CH];
    int             m_hold  [`AGC_NUM_CH];
    agc_code_t      last_wr [`AGC_NUM_CH];          // last code seen per latch enable
    int             wr_ch [$];                      // write order log

    tb_clock_gen i_clock_gen (
        .axi_clk    (axi_clk),
        .axi_resetn (axi_resetn)
    );

    agc_dsa_top i_dut (
        .axi_clk          (axi_clk),
        .axi_resetn       (axi_resetn),
        .adc_over_range   (adc_or),
        .adc_over_voltage (adc_ov),
        .adcp_disable     (dis),
        .ps_rxdsa         (ps),
        .ps_bypass_lna    (byp),
        .pl_rxdsa         (pl_rxdsa),
        .rx_lna_bypass    (rx_lna_bypass),
        .dsa_bus          (dsa_bus)
    );

    task automatic check_code(input string name, input agc_code_t got, input agc_code_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bus(input string name, input dsa_bus_t got, input dsa_bus_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bypass(input string name, input logic [`AGC_NUM_CH-1:0] got,
                                input logic [`AGC_NUM_CH-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [`AGC_NUM_CH-1:0] model_bypass();
        logic [`AGC_NUM_CH-1:0] b;
        for (int c = 0; c < `AGC_NUM_CH; c++) begin
            b[c] = byp[c] | (~dis[c] & (m_code[c] >= `AGC_LNA_THRESH));
        end
        return b;
    endfunction

    // counts clock-enable ticks after the current edge
    task automatic wait_ticks(input int k);
        int seen;
        int clocks;
        seen   = 0;
        clocks = 0;
        while (seen < k && clocks < k * `AGC_TICK_DIV + 8) begin
            @(posedge axi_clk);
            clocks++;
            if (i_dut.i_arbiter.tick) seen++;       // pre-edge value
        end
        if (seen < k) begin
            $display("timeout: only %0d of %0d ticks seen", seen, k);
            errors++;
        end
    endtask

    // quiet bus and every channel's last write equal to its code
    task automatic wait_writes_settled();
        int  clocks;
        bit  match;
        clocks = 0;
        match  = 1'b0;
        while (!match && clocks < 400) begin
            @(negedge axi_clk);
            clocks++;
            match = (dsa_bus.le == '0);
            for (int c = 0; c < `AGC_NUM_CH; c++) begin
                if (last_wr[c] !== pl_rxdsa[c]) match = 1'b0;
            end
        end
        if (!match) begin
            $display("timeout: bus writes did not catch up with the channel codes");
            errors++;
        end
    endtask

    // reference gain loop, steps on the same ticks as the DUT
    always @(posedge axi_clk) begin : gain_model
        agc_code_t nxt;
        int        h;
        int        sum;
        if (!axi_resetn) begin
            for (int c = 0; c < `AGC_NUM_CH; c++) begin
                m_code[c]  <= '0;
                m_prev1[c] <= '0;
                m_prev2[c] <= '0;
                m_hold[c]  <= 0;
            end
        end else if (i_dut.i_arbiter.tick) begin
            for (int c = 0; c < `AGC_NUM_CH; c++) begin
                nxt = m_code[c];
                h   = m_hold[c];
                if (dis[c]) begin
                    nxt = ps[c];
                    h   = 0;
                end else if (adc_ov[c] | adc_or[c]) begin
                    sum = int'(m_code[c]) + (adc_ov[c] ? `AGC_OV_STEP : `AGC_OR_STEP);
                    nxt = (sum > `AGC_CODE_MAX) ? 7'(`AGC_CODE_MAX) : 7'(sum);
                    h   = 0;
                end else if (m_code[c] < ps[c]) begin
                    nxt = ps[c];                    // floor jump
                end else if (h < `AGC_HOLD_TICKS) begin
                    h++;
                end else if (m_code[c] > ps[c]) begin
                    nxt = m_code[c] - 1'b1;         // decay
                end
                m_code[c]  <= nxt;
                m_hold[c]  <= h;
                m_prev1[c] <= m_code[c];
                m_prev2[c] <= m_prev1[c];
            end
        end
    end

    // latch-enable watcher: width, one-hot, data setup and hold
    always @(posedge axi_clk) begin : bus_monitor
        logic [`AGC_NUM_CH-1:0] le_prev;
        agc_code_t              dhist [0:4];
        int                     hi_cnt;
        int                     post_cnt;
        int                     ch;
        if (!axi_resetn) begin
            le_prev  = '0;
            hi_cnt   = 0;
            post_cnt = 0;
            for (int i = 0; i < 5; i++) dhist[i] = '0;
            for (int c = 0; c < `AGC_NUM_CH; c++) last_wr[c] = '0;
        end else begin
            for (int i = 4; i > 0; i--) dhist[i] = dhist[i-1];
            dhist[0] = dsa_bus.data;
            if (dsa_bus.le != '0 && le_prev == '0) begin
                if (!$onehot(dsa_bus.le)) begin
                    $display("error: dsa_bus.le not one-hot, got 0x%h", dsa_bus.le);
                    errors++;
                end
                for (int i = 1; i < 5; i++) begin
                    if (dhist[i] !== dhist[0]) begin
                        $display("bus data changed during the tick before the latch enable");
                        errors++;
                        break;
                    end
                end
                ch = 0;
                for (int c = 0; c < `AGC_NUM_CH; c++) begin
                    if (dsa_bus.le[c]) ch = c;
                end
                if (dsa_bus.data !== m_code[ch] && dsa_bus.data !== m_prev1[ch] &&
                    dsa_bus.data !== m_prev2[ch]) begin
                    $display("error: dsa_bus.data for ch %0d got 0x%h, model 0x%h",
                             ch, dsa_bus.data, m_prev2[ch]);
                    errors++;
                end
                last_wr[ch] = dsa_bus.data;
                wr_ch.push_back(ch);
                hi_cnt   = 1;
                post_cnt = 0;
            end else if (dsa_bus.le != '0) begin
                hi_cnt++;
                if (dsa_bus.le !== le_prev) begin
                    $display("latch enable switched channel while high");
                    errors++;
                end
            end else if (le_prev != '0) begin
                if (hi_cnt != `AGC_TICK_DIV) begin
                    $display("latch enable was high for %0d clocks, not one tick", hi_cnt);
                    errors++;
                end
                post_cnt = 1;
                if (dhist[0] !== dhist[1]) begin
                    $display("bus data changed as the latch enable dropped");
                    errors++;
                end
            end else if (post_cnt > 0 && post_cnt < `AGC_TICK_DIV) begin
                post_cnt++;                         // hold tick after the strobe
                if (dhist[0] !== dhist[1]) begin
                    $display("bus data changed during the tick after the latch enable");
                    errors++;
                end
            end
            le_prev = dsa_bus.le;
        end
    end

    initial begin
        int base;
        int err_before;
        int wr_start;
        int n;
        int passed;
        int failed;
        errors = 0;
        passed = 0;
        failed = 0;
        adc_or = '0;
        adc_ov = '0;
        dis    = '0;
        byp    = 4'ha;                              // visible on bypass during reset
        ps     = '0;
        for (int i = 0; i < NUM_FIELDS * MAX_CASES; i++) case_mem[i] = 32'hffffffff;
        $readmemh("agc_dsa_cases.txt", case_mem);

        n = 0;
        while (axi_resetn !== 1'b1 && n < 20) begin
            @(posedge axi_clk);
            n++;
        end
        if (axi_resetn !== 1'b1) begin
            $display("timeout: reset never released");
            errors++;
        end
        @(negedge axi_clk);
        err_before = errors;
        check_bus("dsa_bus", dsa_bus, '0);
        check_bypass("rx_lna_bypass", rx_lna_bypass, byp);
        if (errors == err_before) begin
            $display("test reset: ok");
            passed++;
        end else begin
            $display("test reset: failed");
            failed++;
        end

        n = 0;
        while (n < MAX_CASES && case_mem[n*NUM_FIELDS+8] !== 32'hffffffff) begin
            base       = n * NUM_FIELDS;
            err_before = errors;
            wr_start   = wr_ch.size();
            @(posedge axi_clk);
            adc_or <= case_mem[base][3:0];
            adc_ov <= case_mem[base+1][3:0];
            dis    <= case_mem[base+2][3:0];
            byp    <= case_mem[base+3][3:0];
            for (int c = 0; c < `AGC_NUM_CH; c++) ps[c] <= case_mem[base+4+c][6:0];
            wait_ticks(case_mem[base+8]);
            @(negedge axi_clk);                     // outputs settled
            for (int c = 0; c < `AGC_NUM_CH; c++) begin
                check_code($sformatf("pl_rxdsa[%0d]", c), pl_rxdsa[c],
                           case_mem[base+9+c][6:0]);
                check_code($sformatf("model code[%0d]", c), m_code[c],
                           case_mem[base+9+c][6:0]);
            end
            check_bypass("rx_lna_bypass", rx_lna_bypass, case_mem[base+13][3:0]);
            check_bypass("rx_lna_bypass vs model", rx_lna_bypass, model_bypass());
            if (case_mem[base+14] != 0) begin
                wait_writes_settled();
                for (int c = 0; c < `AGC_NUM_CH; c++) begin
                    check_code($sformatf("last write[%0d]", c), last_wr[c],
                               case_mem[base+9+c][6:0]);
                end
            end
            if (case_mem[base+14] == 2) begin
                if (wr_ch.size() - wr_start < `AGC_NUM_CH) begin
                    $display("fewer than four writes after all channels changed");
                    errors++;
                end
                for (int i = wr_start + 1; i < wr_ch.size(); i++) begin
                    if (wr_ch[i] != (wr_ch[i-1] + 1) % `AGC_NUM_CH) begin
                        $display("write to ch %0d followed ch %0d, not round-robin",
                                 wr_ch[i], wr_ch[i-1]);
                        errors++;
                    end
                end
            end
            if (errors == err_before) begin
                $display("test case %0d: ok", n + 1);
                passed++;
            end else begin
                $display("test case %0d: failed", n + 1);
                failed++;
            end
            n++;
        end

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d writes",
                 passed + failed, passed, failed, errors, wr_ch.size());
        if (errors == 0 && failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic axi_clk,
    output logic axi_resetn
);

    // 100 ns period
    initial begin
        axi_clk = 1'b0;
        forever #50 axi_clk = ~axi_clk;
    end

    initial begin
        axi_resetn = 1'b0;                          // held for 4 cycles
        repeat (4) @(posedge axi_clk);
        axi_resetn <= 1'b1;
    end

endmodule

`default_nettype wire
